/* common/layerPkg.sv */
`include "layer_consts.svh"

package layerPkg;

	// One input or output activation in fixed point
	typedef logic signed [`ACT_WIDTH-1:0] activation;

	// One multiplier coefficient of a neuron
	typedef logic signed [`ACT_WIDTH-1:0] weight;

	// Bias added before the activation function, also the width of a write word
	typedef logic signed [`BIAS_WIDTH-1:0] biasValue;

	// Running sum of products and bias
	typedef logic signed [`ACC_WIDTH-1:0] accumulator;

	// Weight slot inside one neuron
	typedef logic [`TAP_WIDTH-1:0] tapIndex;

	// Neuron number inside the layer
	typedef logic [`NODE_SEL_WIDTH-1:0] nodeIndex;

	// All inputs of the layer side by side, element 0 in the low bits
	typedef activation [`INPUT_COUNT-1:0] featureVector;

	// One activation per neuron, element 0 in the low bits
	typedef activation [`NODE_COUNT-1:0] layerOutput;

endpackage

/* common/layer_consts.svh */
`ifndef LAYER_CONSTS_SVH
`define LAYER_CONSTS_SVH

// Layer shape
`define INPUT_COUNT 15
`define NODE_COUNT 4

// Data widths
`define ACT_WIDTH 8 // Activations and weights share this width
`define BIAS_WIDTH 16
`define ACC_WIDTH 23 // Room for fifteen full scale products plus the bias

// Weight write addressing
`define TAP_WIDTH 4 // Slots below INPUT_COUNT are weights, the last slot is the bias
`define NODE_SEL_WIDTH 2

`endif

/* hdl/argmaxSelect.sv */
`include "layer_consts.svh"

module argmaxSelect
(
	input logic clk,
	input logic reset,
	input layerPkg::layerOutput nodeOut,
	input logic layerValid,
	output layerPkg::nodeIndex classIndex,
	output layerPkg::activation classScore,
	output logic resultValid
);

	layerPkg::nodeIndex bestIndex;
	layerPkg::activation bestScore;
	layerPkg::activation candidate;

	// Linear scan from node 0 upward
	always_comb
	begin
		bestIndex = '0;
		bestScore = nodeOut[0];
		candidate = '0;
		for (int n = 1; n < `NODE_COUNT; n++)
		begin
			candidate = nodeOut[n];
			if (candidate > bestScore) // Strict compare keeps the lower index on a tie
			begin
				bestIndex = layerPkg::nodeIndex'(n);
				bestScore = candidate;
			end
		end
	end

	// Winner is captured every cycle, the valid bit says which cycles count
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classIndex <= '0;
			classScore <= '0;
			resultValid <= 1'b0;
		end
		else
		begin
			classIndex <= bestIndex;
			classScore <= bestScore;
			resultValid <= layerValid;
		end
	end

endmodule

/* hdl/denseLayer.sv */
`include "layer_consts.svh"

module denseLayer
(
	input logic clk,
	input logic reset,
	input layerPkg::featureVector features,
	input logic sampleValid,
	input logic weightWrite,
	input layerPkg::nodeIndex weightNode,
	input layerPkg::tapIndex weightTap,
	input layerPkg::biasValue weightData,
	output wire layerPkg::layerOutput nodeOut,
	output layerPkg::nodeIndex classIndex,
	output layerPkg::activation classScore,
	output logic resultValid
);

	layerPkg::featureVector featuresReg;
	logic validReg;
	logic [`NODE_COUNT-1:0] nodeWrite;
	layerPkg::tapIndex tapReg;
	layerPkg::biasValue dataReg;

	wire [`NODE_COUNT-1:0] nodeValid;

	inputStage inputStage_i
	(
		.clk(clk),
		.reset(reset),
		.features(features),
		.sampleValid(sampleValid),
		.weightWrite(weightWrite),
		.weightNode(weightNode),
		.weightTap(weightTap),
		.weightData(weightData),
		.featuresReg(featuresReg),
		.validReg(validReg),
		.nodeWrite(nodeWrite),
		.tapReg(tapReg),
		.dataReg(dataReg)
	);

	genvar n;
	generate
		for (n = 0; n < `NODE_COUNT; n++)
		begin : nodeGen
			neuronNode neuronNode_i
			(
				.clk(clk),
				.reset(reset),
				.featuresReg(featuresReg),
				.validReg(validReg),
				.writeEnable(nodeWrite[n]),
				.tapReg(tapReg),
				.dataReg(dataReg),
				.nodeValue(nodeOut[n]),
				.nodeValid(nodeValid[n])
			);
		end
	endgenerate

	// All neurons run in lockstep, node 0 stands for the whole layer
	argmaxSelect argmaxSelect_i
	(
		.clk(clk),
		.reset(reset),
		.nodeOut(nodeOut),
		.layerValid(nodeValid[0]),
		.classIndex(classIndex),
		.classScore(classScore),
		.resultValid(resultValid)
	);

endmodule

/* hdl/inputStage.sv */
`include "layer_consts.svh"

module inputStage
(
	input logic clk,
	input logic reset,
	input layerPkg::featureVector features,
	input logic sampleValid,
	input logic weightWrite,
	input layerPkg::nodeIndex weightNode,
	input layerPkg::tapIndex weightTap,
	input layerPkg::biasValue weightData,
	output layerPkg::featureVector featuresReg,
	output logic validReg,
	output logic [`NODE_COUNT-1:0] nodeWrite,
	output layerPkg::tapIndex tapReg,
	output layerPkg::biasValue dataReg
);

	logic [`NODE_COUNT-1:0] writeDecode;

	// One-hot enable from the node address
	always_comb
	begin
		writeDecode = '0;
		for (int n = 0; n < `NODE_COUNT; n++)
		begin
			if (weightWrite && (weightNode == layerPkg::nodeIndex'(n)))
			begin
				writeDecode[n] = 1'b1;
			end
		end
	end

	// Sample path
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			featuresReg <= '0; // Keeps the neuron sums at zero until the first sample
			validReg <= 1'b0;
		end
		else
		begin
			featuresReg <= features;
			validReg <= sampleValid;
		end
	end

	// Write enables
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			nodeWrite <= '0;
		end
		else
		begin
			nodeWrite <= writeDecode;
		end
	end

	// Write address and data only move with a write
	always_ff @(posedge clk)
	begin
		if (weightWrite)
		begin
			tapReg <= weightTap;
			dataReg <= weightData; // Neurons take the low byte for a weight slot
		end
	end

endmodule

/* neuron/neuronNode.sv */
`include "layer_consts.svh"

module neuronNode
(
	input logic clk,
	input logic reset,
	input layerPkg::featureVector featuresReg,
	input logic validReg,
	input logic writeEnable,
	input layerPkg::tapIndex tapReg,
	input layerPkg::biasValue dataReg,
	output layerPkg::activation nodeValue,
	output logic nodeValid
);

	localparam int fracBits = 6; // Sum carries six fraction bits above the activation scale
	localparam layerPkg::accumulator roundHalf = 1 << (fracBits - 1);
	localparam layerPkg::accumulator maxOut = (1 << (`ACT_WIDTH - 1)) - 1;

	layerPkg::weight weights [`INPUT_COUNT];
	layerPkg::biasValue bias;

	layerPkg::accumulator products [`INPUT_COUNT];
	layerPkg::accumulator sumNext;
	layerPkg::accumulator sumReg;
	logic sumValid;

	layerPkg::accumulator roundedSum;
	layerPkg::accumulator scaledSum;
	layerPkg::activation clippedValue;

	// Coefficient registers, the slot after the last weight is the bias
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `INPUT_COUNT; i++)
			begin
				weights[i] <= '0;
			end
			bias <= '0;
		end
		else if (writeEnable)
		begin
			for (int i = 0; i < `INPUT_COUNT; i++)
			begin
				if (tapReg == layerPkg::tapIndex'(i))
				begin
					weights[i] <= dataReg[`ACT_WIDTH-1:0];
				end
			end
			if (tapReg == layerPkg::tapIndex'(`INPUT_COUNT))
			begin
				bias <= dataReg;
			end
		end
	end

	// Products widened to the accumulator before summing
	always_comb
	begin
		for (int i = 0; i < `INPUT_COUNT; i++)
		begin
			products[i] = layerPkg::accumulator'($signed(featuresReg[i]))
				* layerPkg::accumulator'(weights[i]);
		end
	end

	always_comb
	begin
		sumNext = layerPkg::accumulator'(bias);
		for (int i = 0; i < `INPUT_COUNT; i++)
		begin
			sumNext = sumNext + products[i];
		end
	end

	// Stage 1
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
			sumValid <= 1'b0;
		end
		else
		begin
			sumReg <= sumNext;
			sumValid <= validReg;
		end
	end

	// Clipped ReLU, rounding happens before the saturation check so 128 cannot slip through
	always_comb
	begin
		roundedSum = sumReg + roundHalf;
		scaledSum = roundedSum >>> fracBits;
		if (sumReg < 0)
		begin
			clippedValue = '0;
		end
		else if (scaledSum > maxOut)
		begin
			clippedValue = maxOut[`ACT_WIDTH-1:0];
		end
		else
		begin
			clippedValue = scaledSum[`ACT_WIDTH-1:0];
		end
	end

	// Stage 2
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			nodeValue <= '0;
			nodeValid <= 1'b0;
		end
		else
		begin
			nodeValue <= clippedValue;
			nodeValid <= sumValid;
		end
	end

endmodule

/* tb.f */
+incdir+common
+incdir+verif
common/layerPkg.sv
hdl/inputStage.sv
neuron/neuronNode.sv
hdl/argmaxSelect.sv
hdl/denseLayer.sv
verif/layerTb.sv

/* verif/layerTbUtil.svh */
`ifndef LAYER_TB_UTIL_SVH
`define LAYER_TB_UTIL_SVH

logic [15:0] lfsrState = 16'd31;

// Galois LFSR, one step per bit handed out
function automatic logic lfsrBit();
	logic outBit;
	outBit = lfsrState[0];
	lfsrState = lfsrState >> 1;
	if (outBit)
	begin
		lfsrState = lfsrState ^ 16'hB400; // Taps 16, 14, 13, 11
	end
	return outBit;
endfunction

// Random two's complement value of the given width, sign extended
function automatic int randomSigned(int width);
	int value;
	value = 0;
	for (int b = 0; b < width; b++)
	begin
		value = (value << 1) | int'(lfsrBit());
	end
	if (value[width-1])
	begin
		value = value - (1 << width);
	end
	return value;
endfunction

// Bias plus dot product, then ReLU, round by half an LSB, and clip at 127
function automatic int neuronModel(int node, layerPkg::featureVector f);
	int sum;
	int scaled;
	sum = biasTable[node];
	for (int i = 0; i < `INPUT_COUNT; i++)
	begin
		sum = sum + int'($signed(f[i])) * weightTable[node][i];
	end
	if (sum < 0)
	begin
		return 0;
	end
	scaled = (sum + 32) / 64; // Sum is not negative here, so division matches the shift
	if (scaled > 127)
	begin
		return 127;
	end
	return scaled;
endfunction

// First node holding the largest value
function automatic int bestNode(layerPkg::layerOutput values);
	int best;
	best = 0;
	for (int n = 1; n < `NODE_COUNT; n++)
	begin
		if ($signed(values[n]) > $signed(values[best]))
		begin
			best = n;
		end
	end
	return best;
endfunction

task automatic compareValue(string testName, string field, logic signed [31:0] expected,
	logic signed [31:0] actual);
	if (expected !== actual)
	begin
		$display("ERROR %s %s: expected %0d, actual %0d", testName, field, expected, actual);
		stopRun();
	end
endtask

`endif

/* verif/layerTb.sv */
`include "layer_consts.svh"

module layerTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int maxRows = 64;

	logic clk = 1'b0;
	logic reset;
	layerPkg::featureVector features;
	logic sampleValid;
	logic weightWrite;
	layerPkg::nodeIndex weightNode;
	layerPkg::tapIndex weightTap;
	layerPkg::biasValue weightData;
	layerPkg::layerOutput nodeOut;
	layerPkg::nodeIndex classIndex;
	layerPkg::activation classScore;
	logic resultValid;

	// Copy of the coefficients the DUT was given, used by the model
	int weightTable [`NODE_COUNT][`INPUT_COUNT];
	int biasTable [`NODE_COUNT];

	string rowName [maxRows];
	layerPkg::featureVector rowFeatures [maxRows];
	logic rowStrobe [maxRows];
	layerPkg::layerOutput rowExpOut [maxRows];
	layerPkg::nodeIndex rowExpIndex [maxRows];
	layerPkg::activation rowExpScore [maxRows];
	int rowCount;

	`include "layerTbUtil.svh"

	denseLayer denseLayer_i
	(
		.clk(clk),
		.reset(reset),
		.features(features),
		.sampleValid(sampleValid),
		.weightWrite(weightWrite),
		.weightNode(weightNode),
		.weightTap(weightTap),
		.weightData(weightData),
		.nodeOut(nodeOut),
		.classIndex(classIndex),
		.classScore(classScore),
		.resultValid(resultValid)
	);

	always #5 clk = ~clk;

	task automatic stopRun();
		$display("Test failures found");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic waitCycles(int count);
		for (int i = 0; i < count; i++)
		begin
			@(negedge clk);
		end
	endtask

	task automatic waitIdle();
		int waited;
		waited = 0;
		@(negedge clk);
		while (resultValid && waited < 20)
		begin
			@(negedge clk);
			waited++;
		end
		if (resultValid)
		begin
			$display("Timed out waiting for resultValid to go low");
			stopRun();
		end
	endtask

	// Write lands in the neuron two edges after the strobe is registered
	task automatic writeSlot(int node, int tap, int value);
		@(negedge clk);
		weightWrite = 1'b1;
		weightNode = layerPkg::nodeIndex'(node);
		weightTap = layerPkg::tapIndex'(tap);
		weightData = layerPkg::biasValue'(value);
		@(negedge clk);
		weightWrite = 1'b0;
		if (tap < `INPUT_COUNT)
		begin
			weightTable[node][tap] = value;
		end
		else
		begin
			biasTable[node] = value;
		end
	endtask

	function automatic layerPkg::featureVector randomVector(int width);
		layerPkg::featureVector f;
		for (int i = 0; i < `INPUT_COUNT; i++)
		begin
			f[i] = layerPkg::activation'(randomSigned(width));
		end
		return f;
	endfunction

	task automatic fillExpected(int k);
		layerPkg::layerOutput expected;
		int best;
		for (int n = 0; n < `NODE_COUNT; n++)
		begin
			expected[n] = layerPkg::activation'(neuronModel(n, rowFeatures[k]));
		end
		best = bestNode(expected);
		rowExpOut[k] = expected;
		rowExpIndex[k] = layerPkg::nodeIndex'(best);
		rowExpScore[k] = expected[best];
	endtask

	task automatic addRow(string name, layerPkg::featureVector f, logic strobe);
		rowName[rowCount] = name;
		rowFeatures[rowCount] = f;
		rowStrobe[rowCount] = strobe;
		fillExpected(rowCount);
		rowCount++;
	endtask

	// One row per cycle; nodeOut is due three falling edges later, the class one edge after that
	task automatic runTable();
		int k;
		for (int c = 0; c < rowCount + 4; c++)
		begin
			@(negedge clk);
			k = c - 3;
			if (k >= 0 && k < rowCount && rowStrobe[k])
			begin
				for (int n = 0; n < `NODE_COUNT; n++)
				begin
					compareValue(rowName[k], $sformatf("nodeOut[%0d]", n),
						$signed(rowExpOut[k][n]), $signed(nodeOut[n]));
				end
			end
			k = c - 4;
			if (k >= 0)
			begin
				compareValue(rowName[k], "resultValid", rowStrobe[k], resultValid);
				if (rowStrobe[k])
				begin
					compareValue(rowName[k], "classIndex", rowExpIndex[k], classIndex);
					compareValue(rowName[k], "classScore", rowExpScore[k], classScore);
				end
			end
			if (c < rowCount)
			begin
				features = rowFeatures[c];
				sampleValid = rowStrobe[c];
			end
			else
			begin
				features = '0;
				sampleValid = 1'b0;
			end
		end
	endtask

	function automatic layerPkg::featureVector directedVector(int first);
		layerPkg::featureVector f;
		f = randomVector(8); // Only input 0 has a nonzero weight in the directed set
		f[0] = layerPkg::activation'(first);
		return f;
	endfunction

	initial
	begin
		reset = 1'b1;
		features = '0;
		sampleValid = 1'b0;
		weightWrite = 1'b0;
		weightNode = '0;
		weightTap = '0;
		weightData = '0;
		for (int n = 0; n < `NODE_COUNT; n++)
		begin
			for (int i = 0; i < `INPUT_COUNT; i++)
			begin
				weightTable[n][i] = 0;
			end
			biasTable[n] = 0;
		end
		waitCycles(10);
		reset = 1'b0;
		@(negedge clk);
		compareValue("resetState", "resultValid", 0, resultValid);
		compareValue("resetState", "nodeOut", 0, nodeOut);
		compareValue("resetState", "classIndex", 0, classIndex);
		compareValue("resetState", "classScore", 0, classScore);
		waitIdle();

		// Input 0 scaled by 64 lands each node right at its rounding or clipping edge
		writeSlot(0, 0, 64);
		writeSlot(1, 0, 64);
		writeSlot(1, `INPUT_COUNT, 32); // 127 on input 0 gives a sum of 8160, which rounds to 128
		writeSlot(2, 0, 64);
		writeSlot(2, `INPUT_COUNT, -33);
		writeSlot(3, 0, -128);
		waitCycles(2);
		rowCount = 0;
		addRow("tieAtTop", directedVector(127), 1'b1);
		addRow("negativeInput", directedVector(-128), 1'b1);
		addRow("idleGap", directedVector(5), 1'b0);
		addRow("roundUp", directedVector(0), 1'b1);
		addRow("roundDown", directedVector(1), 1'b1);
		addRow("smallSums", directedVector(-1), 1'b1);
		addRow("midRange", directedVector(70), 1'b1);
		runTable();
		waitIdle();

		for (int n = 0; n < `NODE_COUNT; n++)
		begin
			for (int i = 0; i < `INPUT_COUNT; i++)
			begin
				writeSlot(n, i, randomSigned(8));
			end
			writeSlot(n, `INPUT_COUNT, randomSigned(12));
		end
		waitCycles(2);
		rowCount = 0;
		for (int r = 0; r < 24; r++)
		begin
			addRow($sformatf("random%0d", r), randomVector(5), (r % 7) != 3);
		end
		runTable();
		waitIdle();

		// Same vectors again after moving the bias of node 2 alone
		writeSlot(2, `INPUT_COUNT, biasTable[2] + 1280);
		waitCycles(2);
		for (int r = 0; r < rowCount; r++)
		begin
			rowName[r] = $sformatf("rewrite%0d", r);
			fillExpected(r);
		end
		runTable();
		waitIdle();

		$display("All tests passed!");
		$finish;
	end

endmodule
